// File: hw/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

    localparam int WORD_W = 16;

    // control byte, upper half of a command word.
    typedef enum logic [7:0] {
        CMD_REG_SEL  = 8'h80,
        CMD_MEM_RD   = 8'hC0,
        CMD_MEM_WR   = 8'hC1,
        CMD_BURST_RD = 8'hD0,
        CMD_BURST_WR = 8'hD1
    } cmd_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // len counts words and is at least one.
    typedef struct packed {
        mem_op_e     op;
        logic [15:0] len;
        logic [31:0] addr;
    } burst_cmd_t;

    typedef struct packed {
        logic              en;
        logic              we;
        logic [31:0]       addr;
        logic [WORD_W-1:0] wdata;
    } ram_req_t;

endpackage

`default_nettype wire

// File: hw/spi_word_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_word_slave
    import spi_bridge_pkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rst_i,
    input  logic              sck_i,
    input  logic              cs_i,
    input  logic              mosi_i,
    input  logic [WORD_W-1:0] tx_word_i,
    output logic              miso_o,
    output logic [WORD_W-1:0] rx_word_o,
    output logic              rx_valid_o,
    output logic              cs_start_o
);

    localparam int CNT_W = $clog2(WORD_W);

    // two sync stages plus one delayed copy for edge detection.
    logic [2:0]        sck_r;
    logic [2:0]        cs_r;
    logic [1:0]        mosi_r;
    logic              sck_rise;
    logic              sck_fall;
    logic              cs_fall;
    logic              cs_active;
    logic [CNT_W-1:0]  bit_cnt;
    logic [WORD_W-1:0] rx_shift;
    logic [WORD_W-1:0] tx_shift;

    assign sck_rise  = sck_r[1] & ~sck_r[2];
    assign sck_fall  = ~sck_r[1] & sck_r[2];
    assign cs_fall   = ~cs_r[1] & cs_r[2];
    assign cs_active = ~cs_r[1];

    assign cs_start_o = cs_fall;
    assign rx_word_o  = rx_shift;
    assign miso_o     = tx_shift[WORD_W-1];

    always_ff @(posedge clk_50MHz, posedge rst_i) begin
        if (rst_i) begin
            sck_r      <= '0;
            cs_r       <= '1;
            mosi_r     <= '0;
            bit_cnt    <= '0;
            rx_shift   <= '0;
            tx_shift   <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            sck_r      <= {sck_r[1:0], sck_i};
            cs_r       <= {cs_r[1:0], cs_i};
            mosi_r     <= {mosi_r[0], mosi_i};
            rx_valid_o <= 1'b0;
            if (cs_fall) begin
                // first bit goes out on miso before the first sck edge.
                bit_cnt  <= '0;
                tx_shift <= tx_word_i;
            end else if (cs_active) begin
                if (sck_rise) begin
                    rx_shift <= {rx_shift[WORD_W-2:0], mosi_r[1]};
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(WORD_W - 1))
                        rx_valid_o <= 1'b1;
                end
                if (sck_fall)
                    tx_shift <= {tx_shift[WORD_W-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/spi_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decoder
    import spi_bridge_pkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rst_i,
    input  logic [WORD_W-1:0] rx_word_i,
    input  logic              rx_valid_i,
    output logic              sel_we_o,
    output logic [7:0]        sel_addr_o,
    output logic              data_we_o,
    output logic [WORD_W-1:0] data_o,
    output logic              start_o,
    output burst_cmd_t        cmd_o,
    output logic              seq_o,
    output logic [WORD_W-1:0] wdata_o,
    input  logic              busy_i,
    input  logic              seq_ack_i,
    input  logic [WORD_W-1:0] rdata_i
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_BURST_LEN,
        ST_ADDR_LO,
        ST_ADDR_HI,
        ST_WR_DATA,
        ST_SINGLE,
        ST_BURST_START,
        ST_BURST_STEP,
        ST_BURST_WAIT
    } state_t;

    state_t state;
    cmd_e   ctl;
    logic   burst_q;

    assign ctl = cmd_e'(rx_word_i[WORD_W-1:WORD_W-8]);

    always_ff @(posedge clk_50MHz, posedge rst_i) begin
        if (rst_i) begin
            state      <= ST_IDLE;
            burst_q    <= 1'b0;
            sel_we_o   <= 1'b0;
            sel_addr_o <= '0;
            data_we_o  <= 1'b0;
            data_o     <= '0;
            start_o    <= 1'b0;
            cmd_o      <= '0;
            seq_o      <= 1'b0;
            wdata_o    <= '0;
        end else begin
            sel_we_o  <= 1'b0;
            data_we_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rx_valid_i) begin
                        case (ctl)
                            CMD_REG_SEL: begin
                                sel_we_o   <= 1'b1;
                                sel_addr_o <= rx_word_i[7:0];
                            end
                            CMD_MEM_RD, CMD_MEM_WR: begin
                                cmd_o.op  <= (ctl == CMD_MEM_WR) ? OP_WRITE : OP_READ;
                                cmd_o.len <= 16'd1;
                                burst_q   <= 1'b0;
                                state     <= ST_ADDR_LO;
                            end
                            CMD_BURST_RD, CMD_BURST_WR: begin
                                cmd_o.op <= (ctl == CMD_BURST_WR) ? OP_WRITE : OP_READ;
                                burst_q  <= 1'b1;
                                state    <= ST_BURST_LEN;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                ST_BURST_LEN: begin
                    if (rx_valid_i) begin
                        cmd_o.len <= rx_word_i;
                        state     <= ST_ADDR_LO;
                    end
                end
                ST_ADDR_LO: begin
                    if (rx_valid_i) begin
                        cmd_o.addr[15:0] <= rx_word_i;
                        state            <= ST_ADDR_HI;
                    end
                end
                ST_ADDR_HI: begin
                    if (rx_valid_i) begin
                        cmd_o.addr[31:16] <= rx_word_i;
                        if (!burst_q && cmd_o.op == OP_WRITE)
                            state <= ST_WR_DATA;
                        else
                            state <= ST_BURST_START;
                    end
                end
                ST_WR_DATA: begin
                    if (rx_valid_i) begin
                        wdata_o <= rx_word_i;
                        state   <= ST_BURST_START;
                    end
                end
                ST_BURST_START: begin
                    // busy may still be held by the previous access.
                    if (start_o) begin
                        if (busy_i) begin
                            start_o <= 1'b0;
                            if (burst_q) begin
                                state <= ST_BURST_STEP;
                            end else begin
                                seq_o <= 1'b1;
                                state <= ST_SINGLE;
                            end
                        end
                    end else if (!busy_i) begin
                        start_o <= 1'b1;
                    end
                end
                ST_SINGLE: begin
                    if (seq_ack_i) begin
                        seq_o <= 1'b0;
                        if (cmd_o.op == OP_READ) begin
                            data_we_o <= 1'b1;
                            data_o    <= rdata_i;
                        end
                        state <= ST_IDLE;
                    end
                end
                ST_BURST_STEP: begin
                    if (!busy_i) begin
                        state <= ST_IDLE;
                    end else if (rx_valid_i) begin
                        wdata_o <= rx_word_i;
                        seq_o   <= 1'b1;
                        state   <= ST_BURST_WAIT;
                    end
                end
                ST_BURST_WAIT: begin
                    if (seq_ack_i) begin
                        seq_o <= 1'b0;
                        if (cmd_o.op == OP_READ) begin
                            data_we_o <= 1'b1;
                            data_o    <= rdata_i;
                        end
                        state <= ST_BURST_STEP;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/readback_regs.sv
`timescale 1ns/1ps
`default_nettype none

module readback_regs
    import spi_bridge_pkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rst_i,
    input  logic              sel_we_i,
    input  logic [7:0]        sel_addr_i,
    input  logic              data_we_i,
    input  logic [WORD_W-1:0] data_i,
    input  logic              busy_i,
    output logic [WORD_W-1:0] tx_word_o
);

    logic [7:0]        sel_q;
    logic [WORD_W-1:0] data_q;

    always_ff @(posedge clk_50MHz, posedge rst_i) begin
        if (rst_i) begin
            sel_q  <= '0;
            data_q <= '0;
        end else begin
            if (sel_we_i)
                sel_q <= sel_addr_i;
            if (data_we_i)
                data_q <= data_i;
        end
    end

    // a running burst streams the data word back regardless of the select.
    always_comb begin
        if (busy_i) begin
            tx_word_o = data_q;
        end else begin
            case (sel_q)
                8'h00:   tx_word_o = 16'h1234;
                8'h01:   tx_word_o = 16'h5678;
                8'h02:   tx_word_o = 16'hABCD;
                8'h03:   tx_word_o = 16'hEF01;
                8'h04:   tx_word_o = data_q;
                8'h05:   tx_word_o = {{(WORD_W-1){1'b0}}, busy_i};
                default: tx_word_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_burst_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mem_burst_engine
    import spi_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk_50MHz,
    input  logic              rst_i,
    input  logic              start_i,
    input  burst_cmd_t        cmd_i,
    input  logic              seq_i,
    input  logic [WORD_W-1:0] wdata_i,
    output logic              busy_o,
    output logic              seq_ack_o,
    output logic [WORD_W-1:0] rdata_o,
    output ram_req_t          ram_o,
    input  logic              ram_ack_i,
    input  logic [WORD_W-1:0] ram_rdata_i
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_WAIT_SEQ,
        E_REQ,
        E_WAIT_ACK,
        E_HOLD_ACK,
        E_DONE
    } state_t;

    state_t            state;
    mem_op_e           op_q;
    logic [15:0]       count_q;
    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] wdata_q;

    always_ff @(posedge clk_50MHz, posedge rst_i) begin
        if (rst_i) begin
            state     <= E_IDLE;
            busy_o    <= 1'b0;
            seq_ack_o <= 1'b0;
            op_q      <= OP_READ;
            count_q   <= '0;
            addr_q    <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (start_i) begin
                        op_q    <= cmd_i.op;
                        count_q <= cmd_i.len;
                        addr_q  <= cmd_i.addr[ADDR_W-1:0];
                        busy_o  <= 1'b1;
                        state   <= E_WAIT_SEQ;
                    end
                end
                E_WAIT_SEQ: if (seq_i) state <= E_REQ;
                E_REQ:      state <= E_WAIT_ACK;
                E_WAIT_ACK: begin
                    if (ram_ack_i) begin
                        seq_ack_o <= 1'b1;
                        addr_q    <= addr_q + 1'b1;
                        count_q   <= count_q - 1'b1;
                        state     <= (count_q == 16'd1) ? E_DONE : E_HOLD_ACK;
                    end
                end
                E_HOLD_ACK: begin
                    if (!seq_i) begin
                        seq_ack_o <= 1'b0;
                        state     <= E_WAIT_SEQ;
                    end
                end
                E_DONE: begin
                    if (!seq_i) begin
                        seq_ack_o <= 1'b0;
                        busy_o    <= 1'b0;
                        state     <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (state == E_WAIT_SEQ && seq_i)
            wdata_q <= wdata_i;
        if (state == E_WAIT_ACK && ram_ack_i)
            rdata_o <= ram_rdata_i;
    end

    // one access per step, address wraps inside the RAM.
    always_comb begin
        ram_o.en    = (state == E_REQ);
        ram_o.we    = (op_q == OP_WRITE);
        ram_o.addr  = 32'(addr_q);
        ram_o.wdata = wdata_q;
    end

endmodule

`default_nettype wire

// File: hw/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram
    import spi_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk_50MHz,
    input  logic              rst_i,
    input  ram_req_t          req_i,
    output logic [WORD_W-1:0] rdata_o,
    output logic              ack_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [WORD_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] idx;

    assign idx = req_i.addr[ADDR_W-1:0];

    // contents start cleared.
    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk_50MHz) begin
        if (req_i.en) begin
            if (req_i.we)
                mem[idx] <= req_i.wdata;
            rdata_o <= mem[idx];
        end
    end

    always_ff @(posedge clk_50MHz, posedge rst_i) begin
        if (rst_i)
            ack_o <= 1'b0;
        else
            ack_o <= req_i.en;
    end

endmodule

`default_nettype wire

// File: hw/spi_mem_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mem_bridge_top
    import spi_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic clk_50MHz,
    input  logic rst_i,
    input  logic spi_sck_i,
    input  logic spi_cs_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);

    logic [WORD_W-1:0] rx_word;
    logic              rx_valid;
    logic [WORD_W-1:0] tx_word;
    logic              sel_we;
    logic [7:0]        sel_addr;
    logic              data_we;
    logic [WORD_W-1:0] data;
    logic              start;
    burst_cmd_t        cmd;
    logic              seq;
    logic [WORD_W-1:0] wdata;
    logic              busy;
    logic              seq_ack;
    logic [WORD_W-1:0] eng_rdata;
    ram_req_t          ram_req;
    logic [WORD_W-1:0] ram_rdata;
    logic              ram_ack;

    spi_word_slave u_slave (
        .clk_50MHz  (clk_50MHz),
        .rst_i      (rst_i),
        .sck_i      (spi_sck_i),
        .cs_i       (spi_cs_i),
        .mosi_i     (spi_mosi_i),
        .tx_word_i  (tx_word),
        .miso_o     (spi_miso_o),
        .rx_word_o  (rx_word),
        .rx_valid_o (rx_valid),
        .cs_start_o ()
    );

    spi_cmd_decoder u_decoder (
        .clk_50MHz  (clk_50MHz),
        .rst_i      (rst_i),
        .rx_word_i  (rx_word),
        .rx_valid_i (rx_valid),
        .sel_we_o   (sel_we),
        .sel_addr_o (sel_addr),
        .data_we_o  (data_we),
        .data_o     (data),
        .start_o    (start),
        .cmd_o      (cmd),
        .seq_o      (seq),
        .wdata_o    (wdata),
        .busy_i     (busy),
        .seq_ack_i  (seq_ack),
        .rdata_i    (eng_rdata)
    );

    readback_regs u_regs (
        .clk_50MHz  (clk_50MHz),
        .rst_i      (rst_i),
        .sel_we_i   (sel_we),
        .sel_addr_i (sel_addr),
        .data_we_i  (data_we),
        .data_i     (data),
        .busy_i     (busy),
        .tx_word_o  (tx_word)
    );

    mem_burst_engine #(
        .ADDR_W (ADDR_W)
    ) u_engine (
        .clk_50MHz   (clk_50MHz),
        .rst_i       (rst_i),
        .start_i     (start),
        .cmd_i       (cmd),
        .seq_i       (seq),
        .wdata_i     (wdata),
        .busy_o      (busy),
        .seq_ack_o   (seq_ack),
        .rdata_o     (eng_rdata),
        .ram_o       (ram_req),
        .ram_ack_i   (ram_ack),
        .ram_rdata_i (ram_rdata)
    );

    word_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk_50MHz (clk_50MHz),
        .rst_i     (rst_i),
        .req_i     (ram_req),
        .rdata_o   (ram_rdata),
        .ack_o     (ram_ack)
    );

endmodule

`default_nettype wire

// File: bench/spi_mem_bridge_sva.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mem_bridge_sva
    import spi_bridge_pkg::*;
(
    input logic     clk_50MHz,
    input logic     rst_i,
    input logic     rx_valid_i,
    input logic     busy_i,
    input logic     seq_i,
    input logic     seq_ack_i,
    input logic     ram_ack_i,
    input ram_req_t ram_req_i
);

    rx_valid_pulse: assert property (@(posedge clk_50MHz) disable iff (rst_i)
        rx_valid_i |=> !rx_valid_i)
        else $error("rx_valid stayed high for more than one cycle");

    // the RAM is only touched from inside an engine transaction.
    ram_en_in_busy: assert property (@(posedge clk_50MHz) disable iff (rst_i)
        ram_req_i.en |-> busy_i)
        else $error("RAM enable seen while the engine was idle");

    seq_ack_rise: assert property (@(posedge clk_50MHz) disable iff (rst_i)
        $rose(seq_ack_i) |-> seq_i)
        else $error("seq_ack rose while seq was low");

    // the RAM answers on the next cycle and the engine passes it on one cycle later.
    ram_ack_delay: assert property (@(posedge clk_50MHz) disable iff (rst_i)
        ram_req_i.en |=> ram_ack_i ##1 seq_ack_i)
        else $error("RAM ack or seq_ack did not follow the RAM enable in time");

endmodule

bind spi_mem_bridge_top spi_mem_bridge_sva u_sva (
    .clk_50MHz  (clk_50MHz),
    .rst_i      (rst_i),
    .rx_valid_i (rx_valid),
    .busy_i     (busy),
    .seq_i      (seq),
    .seq_ack_i  (seq_ack),
    .ram_ack_i  (ram_ack),
    .ram_req_i  (ram_req)
);

`default_nettype wire

// File: bench/tb_spi_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_mem_bridge
    import spi_bridge_pkg::*;
();

    localparam int ADDR_W   = 8;
    localparam int DEPTH    = 2 ** ADDR_W;
    localparam int HALF_SCK = 4;
    localparam int CS_GAP   = 16;
    // about 80 words of roughly 150 clocks each, plus margin.
    localparam int MAX_CYCLES = 20000;

    logic clk_50MHz;
    logic rst_i;
    logic spi_sck;
    logic spi_cs;
    logic spi_mosi;
    logic spi_miso;

    logic [WORD_W-1:0] ram_model [DEPTH];
    logic [7:0]        sel_model;
    logic [WORD_W-1:0] data_model;
    logic              busy_model;

    logic [WORD_W-1:0] exp_q [$];
    logic [WORD_W-1:0] got_q [$];
    string             name_q [$];
    int                errors;
    int                checks;
    int                cycle_cnt;

    spi_mem_bridge_top #(
        .ADDR_W (ADDR_W)
    ) DUT (
        .clk_50MHz  (clk_50MHz),
        .rst_i      (rst_i),
        .spi_sck_i  (spi_sck),
        .spi_cs_i   (spi_cs),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // response the host should see at the start of the next frame.
    function automatic logic [WORD_W-1:0] expected_reg(input logic [7:0] sel,
                                                       input logic [WORD_W-1:0] data_word,
                                                       input logic busy);
        if (busy)
            return data_word;
        // the select only answers while idle, so the status burst bit is clear.
        case (sel)
            8'h00:   return 16'h1234;
            8'h01:   return 16'h5678;
            8'h02:   return 16'hABCD;
            8'h03:   return 16'hEF01;
            8'h04:   return data_word;
            8'h05:   return '0;
            default: return '0;
        endcase
    endfunction

    // mode 0 host, one word per cs low period.
    task automatic send_word(input logic [WORD_W-1:0] tx, output logic [WORD_W-1:0] rx);
        @(negedge clk_50MHz);
        spi_cs = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            spi_mosi = tx[i];
            repeat (HALF_SCK) @(negedge clk_50MHz);
            spi_sck = 1'b1;
            rx[i] = spi_miso;
            repeat (HALF_SCK) @(negedge clk_50MHz);
            spi_sck = 1'b0;
        end
        repeat (HALF_SCK) @(negedge clk_50MHz);
        spi_cs   = 1'b1;
        spi_mosi = 1'b0;
        repeat (CS_GAP) @(negedge clk_50MHz);
    endtask

    task automatic xfer(input logic [WORD_W-1:0] word, input string what);
        logic [WORD_W-1:0] expected;
        logic [WORD_W-1:0] resp;
        expected = expected_reg(sel_model, data_model, busy_model);
        send_word(word, resp);
        exp_q.push_back(expected);
        got_q.push_back(resp);
        name_q.push_back(what);
    endtask

    task automatic select_reg(input logic [7:0] sel);
        xfer({8'h80, sel}, $sformatf("select %02h", sel));
        sel_model = sel;
    endtask

    task automatic write_single(input logic [31:0] addr, input logic [WORD_W-1:0] data);
        xfer(16'hC100, "write command");
        xfer(addr[15:0], "address low");
        xfer(addr[31:16], "address high");
        xfer(data, "write data");
        ram_model[addr[ADDR_W-1:0]] = data;
    endtask

    task automatic read_single(input logic [31:0] addr);
        xfer(16'hC000, "read command");
        xfer(addr[15:0], "address low");
        xfer(addr[31:16], "address high");
        data_model = ram_model[addr[ADDR_W-1:0]];
    endtask

    task automatic burst_write(input logic [31:0] base, input int n);
        logic [WORD_W-1:0] w;
        logic [ADDR_W-1:0] idx;
        xfer(16'hD100, "burst write command");
        xfer(16'(n), "burst length");
        xfer(base[15:0], "address low");
        xfer(base[31:16], "address high");
        busy_model = 1'b1;
        idx = base[ADDR_W-1:0];
        for (int k = 0; k < n; k++) begin
            w = WORD_W'($urandom);
            xfer(w, $sformatf("burst write data %0d", k));
            ram_model[idx] = w;
            idx = idx + 1'b1;
        end
        busy_model = 1'b0;
    endtask

    task automatic burst_read(input logic [31:0] base, input int n);
        logic [ADDR_W-1:0] idx;
        xfer(16'hD000, "burst read command");
        xfer(16'(n), "burst length");
        xfer(base[15:0], "address low");
        xfer(base[31:16], "address high");
        busy_model = 1'b1;
        idx = base[ADDR_W-1:0];
        // each word triggers one read, its result shows up in the next frame.
        for (int k = 0; k < n; k++) begin
            xfer(WORD_W'($urandom), $sformatf("burst read data %0d", k));
            data_model = ram_model[idx];
            idx = idx + 1'b1;
        end
        busy_model = 1'b0;
    endtask

    always @(posedge clk_50MHz) begin : compare
        logic [WORD_W-1:0] got;
        logic [WORD_W-1:0] expected;
        string             what;
        while (got_q.size() > 0) begin
            got      = got_q.pop_front();
            expected = exp_q.pop_front();
            what     = name_q.pop_front();
            checks++;
            assert (got == expected) else begin
                errors++;
                $display("[ERROR] t=%0t spi_miso_o (%s): expected %h, got %h",
                         $time, what, expected, got);
            end
        end
    end

    always @(posedge clk_50MHz) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("checks %0d, errors %0d, timeouts 1", checks, errors);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        logic [31:0]       base;
        logic [31:0]       addr;
        logic [WORD_W-1:0] data;
        int                n;
        clk_50MHz  = 1'b0;
        rst_i      = 1'b1;
        spi_sck    = 1'b0;
        spi_cs     = 1'b1;
        spi_mosi   = 1'b0;
        errors     = 0;
        checks     = 0;
        cycle_cnt  = 0;
        sel_model  = '0;
        data_model = '0;
        busy_model = 1'b0;
        void'($urandom(1848));
        for (int i = 0; i < DEPTH; i++)
            ram_model[i] = '0;
        repeat (16) @(negedge clk_50MHz);
        rst_i = 1'b0;
        repeat (4) @(negedge clk_50MHz);

        // identification registers and an unused select.
        for (int s = 0; s < 4; s++)
            select_reg(8'(s));
        xfer(16'h0000, "filler");
        select_reg(8'h07);
        xfer(16'h0000, "filler");

        addr = $urandom;
        data = WORD_W'($urandom);
        write_single(addr, data);
        read_single(addr);
        select_reg(8'h04);
        xfer(16'h0000, "filler");

        select_reg(8'h05);
        xfer(16'h0000, "filler");
        xfer(16'h3C5A, "unknown command");
        select_reg(8'h04);
        xfer(16'h0000, "filler");

        n    = 3 + int'($urandom % 6);
        base = $urandom;
        burst_write(base, n);
        for (int k = 0; k < n; k++) begin
            read_single(base + 32'(k));
            xfer(16'h0000, "readback");
        end

        n = 3 + int'($urandom % 6);
        burst_read(base + 32'd1, n);
        select_reg(8'h04);
        xfer(16'h0000, "filler");

        repeat (4) @(negedge clk_50MHz);
        $display("checks %0d, errors %0d, timeouts 0", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hw/spi_bridge_pkg.sv
hw/spi_word_slave.sv
hw/spi_cmd_decoder.sv
hw/readback_regs.sv
hw/mem_burst_engine.sv
hw/word_ram.sv
hw/spi_mem_bridge_top.sv
bench/spi_mem_bridge_sva.sv
bench/tb_spi_mem_bridge.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the SPI bridge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_spi_mem_bridge -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
